/* sources.f */
src/ncpu_pkg.sv
src/ex_ctrl.sv
src/ex_opnd.sv
src/ex_add.sv
src/ex_alu.sv
src/ex_regfile.sv
src/ex_unit.sv
testbench/tb_ex_unit.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := tb_ex_unit
FILELIST  := sources.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
PASS_MSG  := Test completed successfully

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a listed source or the list itself changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* testbench/tb_ex_unit.sv */
`timescale 1ns/1ps

module tb_ex_unit;
   import ncpu_pkg::*;

   localparam int RESET_CYCLES = 16;
   localparam int N_LOAD = 8;
   localparam int N_REG_OPS = 48;
   localparam int N_IMM_OPS = 48;
   localparam int N_TESTS = 6;
   // Empty queue plus two cycles for the last check
   localparam int DRAIN_CYCLES = 4;
   // Directed issue slots and idles of tests 1, 4, 5 and 6
   localparam int FIXED_CYCLES = 66;
   localparam int RUN_CYCLES = RESET_CYCLES + 1 + 3*N_LOAD + N_REG_OPS + N_IMM_OPS
                               + FIXED_CYCLES + N_TESTS*DRAIN_CYCLES;
   localparam int WATCHDOG_CYCLES = RUN_CYCLES + 100;

   logic                clk;
   logic                arst_n;
   logic                issue_valid;
   ncpu_insn_t          issue_insn;
   logic                wb_valid;
   logic [NCPU_AW-1:0]  wb_rd;
   logic [31:0]         wb_data;
   logic                wb_ovf;
   logic                wb_illegal;

   integer              seed;
   int                  err_count;
   int                  check_count;
   int                  test_errs;
   // Architectural state in program order
   logic [31:0]         mirror [32];
   // Expected WB records, oldest first
   logic [NCPU_AW-1:0]  q_rd [$];
   logic [31:0]         q_data [$];
   logic                q_ovf [$];
   logic                q_ill [$];
   // Head of the queue for the result now on WB
   logic [NCPU_AW-1:0]  exp_rd;
   logic [31:0]         exp_data;
   logic                exp_ovf;
   logic                exp_ill;

   ex_unit #(
      .CONFIG_DW           (32),
      .CONFIG_ENABLE_ASR   (1)
   ) dut0 (
      .clk                 (clk),
      .arst_n              (arst_n),
      .issue_valid         (issue_valid),
      .issue_insn          (issue_insn),
      .wb_valid            (wb_valid),
      .wb_rd               (wb_rd),
      .wb_data             (wb_data),
      .wb_ovf              (wb_ovf),
      .wb_illegal          (wb_illegal)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Bound on the whole run
   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Watchdog expired after %0d cycles with %0d results outstanding",
               WATCHDOG_CYCLES, q_data.size());
      $display("Test failed");
      $finish;
   end

   function automatic ncpu_insn_t build_reg_insn(input logic [5:0] opc, input logic [4:0] rd,
                                                 input logic [4:0] rs1, input logic [4:0] rs2);
      ncpu_insn_t w;
      w = '0;
      w.r_form.opc = opc;
      w.r_form.rd = rd;
      w.r_form.rs1 = rs1;
      w.r_form.rs2 = rs2;
      return w;
   endfunction

   function automatic ncpu_insn_t build_imm_insn(input logic [5:0] opc, input logic [4:0] rd,
                                                 input logic [4:0] rs1, input logic [15:0] imm);
      ncpu_insn_t w;
      w = '0;
      w.i_form.opc = opc;
      w.i_form.rd = rd;
      w.i_form.rs1 = rs1;
      w.i_form.imm = imm;
      return w;
   endfunction

   // Issue one word for a cycle, model it, queue the expected record
   task automatic send_insn(input ncpu_insn_t insn);
      logic [5:0]    opc;
      logic [3:0]    code;
      logic [31:0]   a;
      logic [31:0]   b;
      logic [31:0]   r;
      logic          ovf;
      logic          ill;
      opc = insn.r_form.opc;
      code = opc[3:0];
      a = mirror[insn.r_form.rs1];
      // MHI takes the raw immediate, the rest sign-extend
      if (opc[5])
         b = (code == 4'd8) ? {16'h0, insn.i_form.imm}
                            : {{16{insn.i_form.imm[15]}}, insn.i_form.imm};
      else
         b = mirror[insn.r_form.rs2];
      r = '0;
      ovf = 1'b0;
      ill = 1'b0;
      case (code)
         4'd0:
         begin
            r = a + b;
            ovf = (a[31] == b[31]) && (r[31] != a[31]);
         end
         4'd1:
         begin
            r = a - b;
            ovf = (a[31] != b[31]) && (r[31] != a[31]);
         end
         4'd2: r = a & b;
         4'd3: r = a | b;
         4'd4: r = a ^ b;
         4'd5: r = a << b[4:0];
         4'd6: r = a >> b[4:0];
         4'd7: r = $signed(a) >>> b[4:0];
         4'd8: r = b << 15;
         default: ill = 1'b1;
      endcase
      if (!ill && insn.r_form.rd != 5'd0)
         mirror[insn.r_form.rd] = r;
      q_rd.push_back(insn.r_form.rd);
      q_data.push_back(r);
      q_ovf.push_back(ovf);
      q_ill.push_back(ill);
      issue_valid = 1'b1;
      issue_insn = insn;
      @(negedge clk);
      issue_valid = 1'b0;
   endtask

   task automatic idle(input int n);
      issue_valid = 1'b0;
      repeat (n) @(negedge clk);
   endtask

   // Full 32-bit random value through MHI, shift and XOR immediates
   task automatic load_random_reg(input logic [4:0] rd);
      logic [31:0] rnd;
      rnd = $random(seed);
      send_insn(build_imm_insn(OPC_IMM | OPC_MHI, rd, 5'd0, rnd[31:16]));
      send_insn(build_imm_insn(OPC_IMM | OPC_LSL, rd, rd, 16'd1));
      send_insn(build_imm_insn(OPC_IMM | OPC_XOR, rd, rd, rnd[15:0]));
   endtask

   // Wait out the pipe, then one line for the test
   task automatic finish_test(input int num, input string name);
      while (q_data.size() != 0)
         @(negedge clk);
      idle(2);
      $display("test %0d %s: %0d errors", num, name, err_count - test_errs);
      test_errs = err_count;
   endtask

   // Take the record for the result that is on WB now
   always @(negedge clk)
   begin
      if (arst_n && wb_valid)
      begin
         if (q_data.size() == 0)
         begin
            err_count++;
            $display("A result appeared on WB with no instruction outstanding");
         end
         else
         begin
            exp_rd = q_rd.pop_front();
            exp_data = q_data.pop_front();
            exp_ovf = q_ovf.pop_front();
            exp_ill = q_ill.pop_front();
            check_count++;
         end
      end
   end

   a_reset_quiet: assert property (@(posedge clk) !arst_n |-> (!wb_valid && !wb_illegal))
      else
      begin
         err_count++;
         $display("WB outputs were active during reset");
      end

   // Fixed two-cycle latency, both ways
   a_latency: assert property (@(posedge clk) disable iff (!arst_n)
      wb_valid == $past(issue_valid, 2))
      else
      begin
         err_count++;
         $display("wb_valid did not follow issue_valid by two cycles at %0t", $time);
      end

   a_illegal_alone: assert property (@(posedge clk) disable iff (!arst_n)
      !wb_valid |-> !wb_illegal)
      else
      begin
         err_count++;
         $display("wb_illegal was raised without wb_valid");
      end

   a_wb_rd: assert property (@(posedge clk) disable iff (!arst_n) wb_valid |-> wb_rd == exp_rd)
      else
      begin
         err_count++;
         $display("MISMATCH wb_rd expected %h actual %h", exp_rd, $sampled(wb_rd));
      end

   a_wb_data: assert property (@(posedge clk) disable iff (!arst_n)
      wb_valid |-> wb_data == exp_data)
      else
      begin
         err_count++;
         $display("MISMATCH wb_data expected %h actual %h", exp_data, $sampled(wb_data));
      end

   a_wb_ovf: assert property (@(posedge clk) disable iff (!arst_n)
      wb_valid |-> wb_ovf == exp_ovf)
      else
      begin
         err_count++;
         $display("MISMATCH wb_ovf expected %h actual %h", exp_ovf, $sampled(wb_ovf));
      end

   a_wb_illegal: assert property (@(posedge clk) disable iff (!arst_n)
      wb_valid |-> wb_illegal == exp_ill)
      else
      begin
         err_count++;
         $display("MISMATCH wb_illegal expected %h actual %h", exp_ill, $sampled(wb_illegal));
      end

   initial
   begin
      seed = 32'hf04f_0369;
      err_count = 0;
      check_count = 0;
      test_errs = 0;
      exp_rd = '0;
      exp_data = '0;
      exp_ovf = 1'b0;
      exp_ill = 1'b0;
      issue_valid = 1'b0;
      issue_insn = '0;
      for (int i = 0; i < 32; i++)
         mirror[i] = '0;
      arst_n = 1'b1;
      #1 arst_n = 1'b0;
      repeat (RESET_CYCLES) @(negedge clk);
      arst_n = 1'b1;

      // Quiet pipe, then reads of unwritten registers
      idle(4);
      send_insn(build_reg_insn(OPC_ADD, 5'd1, 5'd2, 5'd3));
      send_insn(build_reg_insn(OPC_OR, 5'd4, 5'd5, 5'd31));
      send_insn(build_imm_insn(OPC_IMM | OPC_XOR, 5'd6, 5'd7, 16'h0000));
      finish_test(1, "reset and zero registers");

      // Register forms over r0..r15
      for (int i = 1; i <= N_LOAD; i++)
         load_random_reg(5'(i));
      for (int i = 0; i < N_REG_OPS; i++)
      begin
         logic [31:0] rnd;
         rnd = $random(seed);
         send_insn(build_reg_insn({3'b000, rnd[2:0]}, {1'b0, rnd[11:8]},
                                  {1'b0, rnd[19:16]}, {1'b0, rnd[27:24]}));
      end
      finish_test(2, "register forms");

      // Immediate forms, MHI included
      for (int i = 0; i < N_IMM_OPS; i++)
      begin
         logic [31:0] rnd;
         logic [31:0] imm_rnd;
         rnd = $random(seed);
         imm_rnd = $random(seed);
         send_insn(build_imm_insn(OPC_IMM | {2'b00, 4'(rnd % 32'd9)}, {1'b0, rnd[11:8]},
                                  {1'b0, rnd[19:16]}, imm_rnd[15:0]));
      end
      finish_test(3, "immediate forms");

      // Consumer at distance 1, 2 and 3 on either source
      for (int s = 0; s < 2; s++)
      begin
         for (int d = 1; d <= 3; d++)
         begin
            send_insn(build_reg_insn(OPC_ADD, 5'd10, 5'd10, 5'd1));
            for (int k = 1; k < d; k++)
               send_insn(build_reg_insn(OPC_XOR, 5'd20, 5'd3, 5'd4));
            if (s == 0)
               send_insn(build_reg_insn(OPC_SUB, 5'd11, 5'd10, 5'd5));
            else
               send_insn(build_reg_insn(OPC_SUB, 5'd11, 5'd5, 5'd10));
         end
      end
      // EX and WB both hold r12, EX must win
      for (int i = 0; i < 8; i++)
         send_insn(build_reg_insn((i % 2 == 0) ? OPC_ADD : OPC_XOR, 5'd12, 5'd12, 5'(i + 1)));
      finish_test(4, "forwarding chains");

      // r0 results are dropped
      send_insn(build_reg_insn(OPC_ADD, 5'd0, 5'd1, 5'd2));
      send_insn(build_reg_insn(OPC_OR, 5'd13, 5'd0, 5'd0));
      send_insn(build_imm_insn(OPC_IMM | OPC_MHI, 5'd0, 5'd0, 16'hffff));
      idle(1);
      send_insn(build_reg_insn(OPC_ADD, 5'd14, 5'd0, 5'd3));
      finish_test(5, "writes to r0");

      // Codes 9 to 15 in both forms, then read the targets back
      for (int c = 9; c < 16; c++)
      begin
         logic [31:0] rnd;
         rnd = $random(seed);
         send_insn(build_reg_insn({2'b00, 4'(c)}, 5'(c), 5'd1, 5'd2));
         send_insn(build_imm_insn(OPC_IMM | {2'b00, 4'(c)}, 5'(c + 7), 5'd3, rnd[15:0]));
      end
      for (int r = 9; r < 23; r++)
         send_insn(build_reg_insn(OPC_OR, 5'd24, 5'(r), 5'd0));
      finish_test(6, "illegal codes");

      $display("tests %0d, results checked %0d, errors %0d", N_TESTS, check_count, err_count);
      if (err_count == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

/* src/ex_unit.sv */
`timescale 1ns/1ps

module ex_unit
#(
   parameter CONFIG_DW = 32,
   parameter CONFIG_ENABLE_ASR = 1
)
(
   input                                  clk,
   input                                  arst_n,
   input                                  issue_valid,
   input ncpu_pkg::ncpu_insn_t            issue_insn,
   output logic                           wb_valid,
   output logic [ncpu_pkg::NCPU_AW-1:0]   wb_rd,
   output logic [CONFIG_DW-1:0]           wb_data,
   output logic                           wb_ovf,
   output logic                           wb_illegal
);
   import ncpu_pkg::*;

   // Issue cycle
   logic [NCPU_ALU_IOPW-1:0]  id_opc_bus;
   logic                      id_imm_sel;
   logic [CONFIG_DW-1:0]      rf_rdata1;
   logic [CONFIG_DW-1:0]      rf_rdata2;
   // EX stage
   logic [NCPU_ALU_IOPW-1:0]  ex_alu_opc_bus;
   logic                      ex_valid;
   logic [NCPU_AW-1:0]        ex_rd;
   logic                      ex_wen;
   logic [CONFIG_DW-1:0]      ex_operand1;
   logic [CONFIG_DW-1:0]      ex_operand2;
   logic [CONFIG_DW-1:0]      add_sum;
   logic                      add_ovf;
   logic [CONFIG_DW-1:0]      alu_result;
   // WB stage
   logic                      wb_wen;

   ex_ctrl #(
      .CONFIG_ENABLE_ASR   (CONFIG_ENABLE_ASR)
   ) u_ctrl (
      .clk                 (clk),
      .arst_n              (arst_n),
      .issue_valid         (issue_valid),
      .issue_insn          (issue_insn),
      .id_opc_bus          (id_opc_bus),
      .id_imm_sel          (id_imm_sel),
      .ex_alu_opc_bus      (ex_alu_opc_bus),
      .ex_valid            (ex_valid),
      .ex_rd               (ex_rd),
      .ex_wen              (ex_wen),
      .wb_valid            (wb_valid),
      .wb_rd               (wb_rd),
      .wb_wen              (wb_wen),
      .wb_illegal          (wb_illegal)
   );

   ex_opnd #(
      .CONFIG_DW           (CONFIG_DW)
   ) u_opnd (
      .clk                 (clk),
      .arst_n              (arst_n),
      .issue_insn          (issue_insn),
      .id_imm_sel          (id_imm_sel),
      .id_opc_bus          (id_opc_bus),
      .rf_rdata1           (rf_rdata1),
      .rf_rdata2           (rf_rdata2),
      .ex_wen              (ex_wen),
      .ex_rd               (ex_rd),
      .alu_result          (alu_result),
      .wb_wen              (wb_wen),
      .wb_rd               (wb_rd),
      .wb_data             (wb_data),
      .ex_operand1         (ex_operand1),
      .ex_operand2         (ex_operand2)
   );

   ex_add #(
      .CONFIG_DW           (CONFIG_DW)
   ) u_add (
      .ex_alu_opc_bus      (ex_alu_opc_bus),
      .ex_operand1         (ex_operand1),
      .ex_operand2         (ex_operand2),
      .add_sum             (add_sum),
      .add_ovf             (add_ovf)
   );

   ex_alu #(
      .CONFIG_DW           (CONFIG_DW),
      .CONFIG_ENABLE_ASR   (CONFIG_ENABLE_ASR)
   ) u_alu (
      .ex_alu_opc_bus      (ex_alu_opc_bus),
      .ex_operand1         (ex_operand1),
      .ex_operand2         (ex_operand2),
      .add_sum             (add_sum),
      .alu_result          (alu_result)
   );

   // Read addresses straight from the issued word
   ex_regfile #(
      .CONFIG_DW           (CONFIG_DW)
   ) u_regfile (
      .clk                 (clk),
      .arst_n              (arst_n),
      .rs1_addr            (issue_insn.r_form.rs1),
      .rs2_addr            (issue_insn.r_form.rs2),
      .alu_result          (alu_result),
      .add_ovf             (add_ovf),
      .wb_wen              (wb_wen),
      .wb_rd               (wb_rd),
      .rf_rdata1           (rf_rdata1),
      .rf_rdata2           (rf_rdata2),
      .wb_data             (wb_data),
      .wb_ovf              (wb_ovf)
   );

   // Empty EX slot feeds a zero result and no overflow into WB
   a_ex_idle_zero: assert property (
      @(posedge clk) disable iff (!arst_n)
      !ex_valid |-> (alu_result == '0 && !add_ovf))
      else $error("Idle EX stage produced a result");

   // Illegal result is all zero and never written back
   a_illegal_wb: assert property (
      @(posedge clk) disable iff (!arst_n)
      wb_illegal |-> (wb_valid && !wb_wen && wb_data == '0 && !wb_ovf))
      else $error("Illegal instruction produced a result");

endmodule

/* src/ex_regfile.sv */
`timescale 1ns/1ps

module ex_regfile
#(
   parameter CONFIG_DW = 32
)
(
   input                                  clk,
   input                                  arst_n,
   input [ncpu_pkg::NCPU_AW-1:0]          rs1_addr,
   input [ncpu_pkg::NCPU_AW-1:0]          rs2_addr,
   // End of EX
   input [CONFIG_DW-1:0]                  alu_result,
   input                                  add_ovf,
   // WB write port
   input                                  wb_wen,
   input [ncpu_pkg::NCPU_AW-1:0]          wb_rd,
   output logic [CONFIG_DW-1:0]           rf_rdata1,
   output logic [CONFIG_DW-1:0]           rf_rdata2,
   output logic [CONFIG_DW-1:0]           wb_data,
   output logic                           wb_ovf
);
   import ncpu_pkg::*;

   localparam int NREGS = 1 << NCPU_AW;

   logic [CONFIG_DW-1:0]   rf_mem [NREGS];
   // Per-entry written flag, so all registers read zero after reset
   logic [NREGS-1:0]       rf_vld;

   // WB result registers, loaded every cycle
   always_ff @(posedge clk)
   begin
      wb_data <= alu_result;
      wb_ovf  <= add_ovf;
   end

   // Array write one edge after capture
   always_ff @(posedge clk)
   begin
      if (wb_wen)
         rf_mem[wb_rd] <= wb_data;
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         rf_vld <= '0;
      else if (wb_wen)
         rf_vld[wb_rd] <= 1'b1;
   end

   // Asynchronous reads; r0 is never flagged, so it reads 0
   assign rf_rdata1 = rf_vld[rs1_addr] ? rf_mem[rs1_addr] : '0;
   assign rf_rdata2 = rf_vld[rs2_addr] ? rf_mem[rs2_addr] : '0;

   // Decode must never let r0 through
   a_no_r0_write: assert property (
      @(posedge clk) disable iff (!arst_n)
      wb_wen |-> (wb_rd != '0))
      else $error("Write to register 0");

endmodule

/* src/ex_alu.sv */
`timescale 1ns/1ps

module ex_alu
#(
   parameter CONFIG_DW = 32,
   parameter CONFIG_ENABLE_ASR = 0
)
(
   input [ncpu_pkg::NCPU_ALU_IOPW-1:0]    ex_alu_opc_bus,
   input [CONFIG_DW-1:0]                  ex_operand1,
   input [CONFIG_DW-1:0]                  ex_operand2,
   // Sum or difference from ex_add
   input [CONFIG_DW-1:0]                  add_sum,
   output logic [CONFIG_DW-1:0]           alu_result
);
   import ncpu_pkg::*;

   logic [CONFIG_DW-1:0]   dat_and;
   logic [CONFIG_DW-1:0]   dat_or;
   logic [CONFIG_DW-1:0]   dat_xor;
   logic [CONFIG_DW-1:0]   dat_shifter;
   logic [CONFIG_DW-1:0]   dat_move;
   logic [CONFIG_DW-1:0]   shift_lsw;
   logic [CONFIG_DW-1:0]   shift_right;
   logic                   sel_adder;
   logic                   sel_shifter;
   logic                   is_lsl;

   // Mirror a word end to end
   function automatic logic [CONFIG_DW-1:0] reverse_bits(input logic [CONFIG_DW-1:0] a);
      logic [CONFIG_DW-1:0] r;
      for (int i = 0; i < CONFIG_DW; i++)
      begin
         r[CONFIG_DW-1-i] = a[i];
      end
      return r;
   endfunction

   assign sel_adder = ex_alu_opc_bus[NCPU_ALU_ADD] | ex_alu_opc_bus[NCPU_ALU_SUB];

   // Bitwise ops
   assign dat_and = ex_operand1 & ex_operand2;
   assign dat_or  = ex_operand1 | ex_operand2;
   assign dat_xor = ex_operand1 ^ ex_operand2;

   // One right shifter serves all three shifts
   // LSL reverses the word on the way in and on the way out
   assign is_lsl = ex_alu_opc_bus[NCPU_ALU_LSL];
   assign shift_lsw = is_lsl ? reverse_bits(ex_operand1) : ex_operand1;

   generate
      if (CONFIG_ENABLE_ASR != 0)
      begin : gen_asr
         logic [CONFIG_DW-1:0]   shift_msw;
         logic [2*CONFIG_DW-1:0] shift_wide;
         // Upper half holds sign copies for ASR, zeros otherwise
         assign shift_msw = ex_alu_opc_bus[NCPU_ALU_ASR] ? {CONFIG_DW{ex_operand1[CONFIG_DW-1]}}
                                                         : '0;
         assign shift_wide = {shift_msw, shift_lsw} >> ex_operand2[4:0];
         assign shift_right = shift_wide[CONFIG_DW-1:0];
      end
      else
      begin : gen_no_asr
         assign shift_right = shift_lsw >> ex_operand2[4:0];
      end
   endgenerate

   assign dat_shifter = is_lsl ? reverse_bits(shift_right) : shift_right;
   assign sel_shifter = is_lsl | ex_alu_opc_bus[NCPU_ALU_LSR] | ex_alu_opc_bus[NCPU_ALU_ASR];

   // MHI, low 17 bits moved up by 15
   assign dat_move = CONFIG_DW'({ex_operand2[16:0], 15'b0});

   // AND-OR mux, an empty bus gives 0
   assign alu_result = ({CONFIG_DW{sel_adder}} & add_sum) |
                       ({CONFIG_DW{ex_alu_opc_bus[NCPU_ALU_AND]}} & dat_and) |
                       ({CONFIG_DW{ex_alu_opc_bus[NCPU_ALU_OR]}} & dat_or) |
                       ({CONFIG_DW{ex_alu_opc_bus[NCPU_ALU_XOR]}} & dat_xor) |
                       ({CONFIG_DW{sel_shifter}} & dat_shifter) |
                       ({CONFIG_DW{ex_alu_opc_bus[NCPU_ALU_MHI]}} & dat_move);

endmodule

/* src/ex_add.sv */
`timescale 1ns/1ps

module ex_add
#(
   parameter CONFIG_DW = 32
)
(
   input [ncpu_pkg::NCPU_ALU_IOPW-1:0]    ex_alu_opc_bus,
   input [CONFIG_DW-1:0]                  ex_operand1,
   input [CONFIG_DW-1:0]                  ex_operand2,
   output logic [CONFIG_DW-1:0]           add_sum,
   output logic                           add_ovf
);
   import ncpu_pkg::*;

   logic                   sel_add;
   logic                   sel_sub;
   logic [CONFIG_DW-1:0]   op2_mux;
   logic                   same_sign;

   assign sel_add = ex_alu_opc_bus[NCPU_ALU_ADD];
   assign sel_sub = ex_alu_opc_bus[NCPU_ALU_SUB];

   // a - b as a + ~b + 1
   assign op2_mux = sel_sub ? ~ex_operand2 : ex_operand2;
   assign add_sum = ex_operand1 + op2_mux + {{(CONFIG_DW-1){1'b0}}, sel_sub};

   // Overflow only if both addends share a sign and the sum flips it
   assign same_sign = (ex_operand1[CONFIG_DW-1] == op2_mux[CONFIG_DW-1]);
   assign add_ovf = (sel_add | sel_sub) & same_sign &
                    (add_sum[CONFIG_DW-1] != ex_operand1[CONFIG_DW-1]);

endmodule

/* src/ex_opnd.sv */
`timescale 1ns/1ps

module ex_opnd
#(
   parameter CONFIG_DW = 32
)
(
   input                                  clk,
   input                                  arst_n,
   input ncpu_pkg::ncpu_insn_t            issue_insn,
   input                                  id_imm_sel,
   input [ncpu_pkg::NCPU_ALU_IOPW-1:0]    id_opc_bus,
   // Register file read ports
   input [CONFIG_DW-1:0]                  rf_rdata1,
   input [CONFIG_DW-1:0]                  rf_rdata2,
   // Bypass from EX
   input                                  ex_wen,
   input [ncpu_pkg::NCPU_AW-1:0]          ex_rd,
   input [CONFIG_DW-1:0]                  alu_result,
   // Bypass from WB
   input                                  wb_wen,
   input [ncpu_pkg::NCPU_AW-1:0]          wb_rd,
   input [CONFIG_DW-1:0]                  wb_data,
   output logic [CONFIG_DW-1:0]           ex_operand1,
   output logic [CONFIG_DW-1:0]           ex_operand2
);
   import ncpu_pkg::*;

   logic [NCPU_AW-1:0]     rs1;
   logic [NCPU_AW-1:0]     rs2;
   logic [15:0]            imm;
   logic [CONFIG_DW-1:0]   src1;
   logic [CONFIG_DW-1:0]   src2;
   logic [CONFIG_DW-1:0]   imm_ext;

   assign rs1 = issue_insn.r_form.rs1;
   assign rs2 = issue_insn.r_form.rs2;
   assign imm = issue_insn.i_form.imm;

   // Youngest producer wins: EX, then WB, then the file
   // wen is never set for r0, so r0 stays zero here
   always_comb
   begin
      if (ex_wen && (ex_rd == rs1))
         src1 = alu_result;
      else if (wb_wen && (wb_rd == rs1))
         src1 = wb_data;
      else
         src1 = rf_rdata1;
   end

   always_comb
   begin
      if (ex_wen && (ex_rd == rs2))
         src2 = alu_result;
      else if (wb_wen && (wb_rd == rs2))
         src2 = wb_data;
      else
         src2 = rf_rdata2;
   end

   // MHI wants the raw 16 bits, everything else is signed
   assign imm_ext = id_opc_bus[NCPU_ALU_MHI] ? {{(CONFIG_DW-16){1'b0}}, imm}
                                             : {{(CONFIG_DW-16){imm[15]}}, imm};

   // EX operand registers
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         ex_operand1 <= '0;
         ex_operand2 <= '0;
      end
      else
      begin
         ex_operand1 <= src1;
         ex_operand2 <= id_imm_sel ? imm_ext : src2;
      end
   end

endmodule

/* src/ex_ctrl.sv */
`timescale 1ns/1ps

module ex_ctrl
#(
   parameter CONFIG_ENABLE_ASR = 0
)
(
   input                                       clk,
   input                                       arst_n,
   input                                       issue_valid,
   input ncpu_pkg::ncpu_insn_t                 issue_insn,
   // Issue cycle, to the operand stage
   output logic [ncpu_pkg::NCPU_ALU_IOPW-1:0]  id_opc_bus,
   output logic                                id_imm_sel,
   // EX stage
   output logic [ncpu_pkg::NCPU_ALU_IOPW-1:0]  ex_alu_opc_bus,
   output logic                                ex_valid,
   output logic [ncpu_pkg::NCPU_AW-1:0]        ex_rd,
   output logic                                ex_wen,
   // WB stage
   output logic                                wb_valid,
   output logic [ncpu_pkg::NCPU_AW-1:0]        wb_rd,
   output logic                                wb_wen,
   output logic                                wb_illegal
);
   import ncpu_pkg::*;

   logic [3:0]          opc_code;
   logic [NCPU_AW-1:0]  issue_rd;
   logic                id_illegal;
   logic                id_wen;
   logic                ex_illegal;

   // Operation code only, bit 5 picks the form
   assign opc_code = issue_insn.r_form.opc[3:0];
   assign issue_rd = issue_insn.r_form.rd;
   assign id_imm_sel = |(issue_insn.r_form.opc & OPC_IMM);

   // Opcode to one-hot bus
   always_comb
   begin
      id_opc_bus = '0;
      case (opc_code)
         OPC_ADD[3:0]: id_opc_bus[NCPU_ALU_ADD] = 1'b1;
         OPC_SUB[3:0]: id_opc_bus[NCPU_ALU_SUB] = 1'b1;
         OPC_AND[3:0]: id_opc_bus[NCPU_ALU_AND] = 1'b1;
         OPC_OR[3:0]:  id_opc_bus[NCPU_ALU_OR]  = 1'b1;
         OPC_XOR[3:0]: id_opc_bus[NCPU_ALU_XOR] = 1'b1;
         OPC_LSL[3:0]: id_opc_bus[NCPU_ALU_LSL] = 1'b1;
         OPC_LSR[3:0]: id_opc_bus[NCPU_ALU_LSR] = 1'b1;
         // Left empty when the ASR path is not built
         OPC_ASR[3:0]: id_opc_bus[NCPU_ALU_ASR] = (CONFIG_ENABLE_ASR != 0);
         OPC_MHI[3:0]: id_opc_bus[NCPU_ALU_MHI] = 1'b1;
         default:      id_opc_bus = '0;
      endcase
   end

   // Empty bus means nothing decoded
   assign id_illegal = ~|id_opc_bus;

   // r0 is never written
   assign id_wen = ~id_illegal & (issue_rd != '0);

   // EX and WB stage control
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         ex_valid       <= 1'b0;
         ex_alu_opc_bus <= '0;
         ex_rd          <= '0;
         ex_wen         <= 1'b0;
         ex_illegal     <= 1'b0;
         wb_valid       <= 1'b0;
         wb_rd          <= '0;
         wb_wen         <= 1'b0;
         wb_illegal     <= 1'b0;
      end
      else
      begin
         ex_valid       <= issue_valid;
         // Idle cycles give a zero bus, so the ALU output is 0
         ex_alu_opc_bus <= issue_valid ? id_opc_bus : '0;
         ex_rd          <= issue_rd;
         ex_wen         <= issue_valid & id_wen;
         ex_illegal     <= issue_valid & id_illegal;
         wb_valid       <= ex_valid;
         wb_rd          <= ex_rd;
         wb_wen         <= ex_wen;
         wb_illegal     <= ex_illegal;
      end
   end

   // Adder, logic, shifter and move never overlap in the mux
   a_ex_bus_onehot: assert property (
      @(posedge clk) disable iff (!arst_n)
      $onehot0(ex_alu_opc_bus))
      else $error("EX opcode bus has more than one bit set");

endmodule

/* src/ncpu_pkg.sv */
package ncpu_pkg;

   // Register address width, 32 architectural registers
   localparam int NCPU_AW = 5;

   // Width of the one-hot opcode bus into the ALU
   localparam int NCPU_ALU_IOPW = 9;

   // Bit positions on the one-hot opcode bus
   localparam int NCPU_ALU_ADD = 0;
   localparam int NCPU_ALU_SUB = 1;
   localparam int NCPU_ALU_AND = 2;
   localparam int NCPU_ALU_OR  = 3;
   localparam int NCPU_ALU_XOR = 4;
   localparam int NCPU_ALU_LSL = 5;
   localparam int NCPU_ALU_LSR = 6;
   localparam int NCPU_ALU_ASR = 7;
   localparam int NCPU_ALU_MHI = 8;

   // Opcode field of the instruction word
   localparam int NCPU_OPC_W = 6;

   // Operation codes in bits 3:0, same order as the bus
   localparam logic [NCPU_OPC_W-1:0] OPC_ADD = 6'd0;
   localparam logic [NCPU_OPC_W-1:0] OPC_SUB = 6'd1;
   localparam logic [NCPU_OPC_W-1:0] OPC_AND = 6'd2;
   localparam logic [NCPU_OPC_W-1:0] OPC_OR  = 6'd3;
   localparam logic [NCPU_OPC_W-1:0] OPC_XOR = 6'd4;
   localparam logic [NCPU_OPC_W-1:0] OPC_LSL = 6'd5;
   localparam logic [NCPU_OPC_W-1:0] OPC_LSR = 6'd6;
   localparam logic [NCPU_OPC_W-1:0] OPC_ASR = 6'd7;
   localparam logic [NCPU_OPC_W-1:0] OPC_MHI = 6'd8;

   // Immediate-form flag, OR'ed onto any code above
   localparam logic [NCPU_OPC_W-1:0] OPC_IMM = 6'b10_0000;

   // Register form, two sources
   typedef struct packed {
      logic [NCPU_OPC_W-1:0] opc;
      logic [NCPU_AW-1:0]    rd;
      logic [NCPU_AW-1:0]    rs1;
      logic [NCPU_AW-1:0]    rs2;
      logic [10:0]           rsvd;
   } ncpu_rform_t;

   // Immediate form, rs2 slot and reserved bits become imm16
   typedef struct packed {
      logic [NCPU_OPC_W-1:0] opc;
      logic [NCPU_AW-1:0]    rd;
      logic [NCPU_AW-1:0]    rs1;
      logic [15:0]           imm;
   } ncpu_iform_t;

   // One 32-bit word, decoded either way
   // opc, rd and rs1 sit in the same bits in both views
   typedef union packed {
      ncpu_rform_t r_form;
      ncpu_iform_t i_form;
   } ncpu_insn_t;

endpackage
